/* sources.f */
+incdir+logic
logic/host_bus_pkg.sv
logic/qdr_mem_pkg.sv
logic/qdr_bridge_csr.sv
logic/qdr_access_sequencer.sv
logic/qdr_burst_assembler.sv
logic/qdr_read_return.sv
logic/qdr_host_bridge.sv
testbench/qdr_sram_model.sv
testbench/tb_qdr_host_bridge.sv

/* testbench/tb_qdr_host_bridge.sv */
`include "qdr_params.svh"

module tb_qdr_host_bridge
  import host_bus_pkg::*;
  import qdr_mem_pkg::*;
();

  localparam int WAIT_LIMIT = 200;

  logic        qdr_clk;
  logic        qdr_rst;
  logic        host_valid;
  logic        host_rnw;
  host_addr_t  host_addr;
  logic [31:0] host_wdata;
  logic [3:0]  host_be;
  logic        host_ready;
  logic        rsp_valid;
  logic [31:0] rsp_rdata;
  logic        rsp_ready;
  logic        cfg_valid;
  logic        cfg_write;
  cfg_reg_e    cfg_addr;
  logic [31:0] cfg_wdata;
  logic        cfg_ready;
  logic        cfg_rvalid;
  logic [31:0] cfg_rdata;
  logic        qdr_req;
  logic        qdr_ack;
  logic [27:0] qdr_addr;
  logic        qdr_r;
  logic        qdr_w;
  qdr_beat_u   qdr_d;
  logic [7:0]  qdr_be;
  qdr_beat_u   qdr_q;

  // model controls
  int ack_delay;
  int model_lat;

  // reference state kept by the testbench
  logic [143:0] ref_mem [logic [27:0]];
  logic [143:0] ref_shadow;
  int           lat_exp;
  logic         fb_exp;
  int           exp_writes;
  int           exp_reads;
  logic [31:0]  exp_rdata;
  int           exp_gap;
  logic [31:0]  cfg_exp;
  // burst and direction of the access in flight
  logic [27:0]  exp_burst;
  logic         exp_rnw;
  // cycles since the last ack cycle
  int           ack_gap;

  int err_count;
  int timeout_count;

  qdr_host_bridge qdr_host_bridge_i (
    .qdr_clk(qdr_clk), .qdr_rst(qdr_rst),
    .host_valid(host_valid), .host_rnw(host_rnw), .host_addr(host_addr),
    .host_wdata(host_wdata), .host_be(host_be), .host_ready(host_ready),
    .rsp_valid(rsp_valid), .rsp_rdata(rsp_rdata), .rsp_ready(rsp_ready),
    .cfg_valid(cfg_valid), .cfg_write(cfg_write), .cfg_addr(cfg_addr),
    .cfg_wdata(cfg_wdata), .cfg_ready(cfg_ready), .cfg_rvalid(cfg_rvalid),
    .cfg_rdata(cfg_rdata), .qdr_req(qdr_req), .qdr_ack(qdr_ack), .qdr_addr(qdr_addr),
    .qdr_r(qdr_r), .qdr_w(qdr_w), .qdr_d(qdr_d), .qdr_be(qdr_be), .qdr_q(qdr_q)
  );

  qdr_sram_model sram_i (
    .qdr_clk(qdr_clk), .qdr_req(qdr_req), .qdr_r(qdr_r), .qdr_w(qdr_w),
    .qdr_addr(qdr_addr), .qdr_d(qdr_d), .qdr_be(qdr_be), .ack_delay(ack_delay),
    .latency(model_lat), .qdr_ack(qdr_ack), .qdr_q(qdr_q)
  );

  initial begin
    qdr_clk = 1'b0;
    forever #5 qdr_clk = ~qdr_clk;
  end

  always @(posedge qdr_clk) begin
    if (qdr_req && qdr_ack) begin
      ack_gap <= 1;
    end else begin
      ack_gap <= ack_gap + 1;
    end
  end

  task automatic log_error(input string msg);
    err_count++;
    $display("** Error at time %0t: %s", $time, msg);
  endtask

  task automatic note_timeout(input string what);
    timeout_count++;
    $display("Timed out waiting for %s at time %0t", what, $time);
  endtask

  // bit position of a word in the burst
  // word_id[1] picks the beat, word_id[0] clear is the upper lane
  function automatic int word_lsb(input logic [1:0] wid);
    return 72 * int'(wid[1]) + (wid[0] ? 0 : 36);
  endfunction

  function automatic int clamp_latency(input logic [31:0] v);
    if (v < `QDR_MIN_LATENCY) begin
      return `QDR_MIN_LATENCY;
    end else if (v > `QDR_MAX_LATENCY) begin
      return `QDR_MAX_LATENCY;
    end
    return int'(v);
  endfunction

  function automatic logic [31:0] expected_cfg(input cfg_reg_e addr);
    case (addr)
      CFG_LATENCY: return 32'(lat_exp);
      CFG_CONTROL: return {31'd0, fb_exp};
      CFG_WRITES:  return 32'(exp_writes);
      default:     return 32'(exp_reads);
    endcase
  endfunction

  // one host access from request to accepted response
  task automatic host_access(input logic rnw, input logic [27:0] baddr,
                             input logic [1:0] wid, input logic [31:0] wdata,
                             input logic [3:0] be);
    int           n;
    int           j;
    int           lsb;
    logic         accepted;
    logic [143:0] line;
    @(negedge qdr_clk);
    lsb  = word_lsb(wid);
    line = ref_mem.exists(baddr) ? ref_mem[baddr] : '0;
    if (rnw) begin
      exp_rdata = line[lsb +: 32];
      exp_gap   = lat_exp + 1 + int'(wid[1]);
    end else begin
      // shadow takes the whole word, memory only the enabled bytes
      ref_shadow[lsb +: 32] = wdata;
      if (fb_exp) begin
        line = ref_shadow;
      end else begin
        for (j = 0; j < 4; j++) begin
          if (be[j]) begin
            line[lsb + 8*j +: 8] = wdata[8*j +: 8];
          end
        end
      end
      ref_mem[baddr] = line;
      exp_rdata      = 32'd0;
      exp_gap        = 2;
    end
    exp_burst  = baddr;
    exp_rnw    = rnw;
    ack_delay  = $urandom % 6;
    host_valid = 1'b1;
    host_rnw   = rnw;
    host_addr  = '{burst: baddr, word_id: wid, byte_off: 2'($urandom)};
    host_wdata = wdata;
    host_be    = be;
    n = 0;
    while (!host_ready && n < WAIT_LIMIT) begin
      @(negedge qdr_clk);
      n++;
    end
    if (!host_ready) begin
      note_timeout("host_ready");
    end
    // transfer happened on the rising edge just passed
    @(negedge qdr_clk);
    host_valid = 1'b0;
    n        = 0;
    accepted = 1'b0;
    while (!accepted && n < WAIT_LIMIT) begin
      @(negedge qdr_clk);
      // stall the response about one cycle in four
      rsp_ready = ($urandom % 4) != 0;
      accepted  = rsp_valid && rsp_ready;
      n++;
    end
    if (!accepted) begin
      note_timeout("an accepted rsp_valid");
    end else if (rnw) begin
      exp_reads++;
    end else begin
      exp_writes++;
    end
  endtask

  task automatic cfg_transfer(input logic wr, input cfg_reg_e addr,
                              input logic [31:0] wdata);
    int n;
    @(negedge qdr_clk);
    cfg_exp   = expected_cfg(addr);
    cfg_valid = 1'b1;
    cfg_write = wr;
    cfg_addr  = addr;
    cfg_wdata = wdata;
    n = 0;
    while (!cfg_ready && n < WAIT_LIMIT) begin
      @(negedge qdr_clk);
      n++;
    end
    if (!cfg_ready) begin
      note_timeout("cfg_ready");
    end
    @(negedge qdr_clk);
    cfg_valid = 1'b0;
    if (wr) begin
      case (addr)
        CFG_LATENCY: begin
          lat_exp   = clamp_latency(wdata);
          model_lat = lat_exp;
        end
        CFG_CONTROL: fb_exp = wdata[0];
        CFG_WRITES:  exp_writes = 0;
        default:     exp_reads = 0;
      endcase
    end
  endtask

  // first cycle out of reset
  a_reset_values: assert property (@(posedge qdr_clk)
    $fell(qdr_rst) |-> !qdr_req && !rsp_valid && !cfg_rvalid && host_ready)
    else log_error("outputs not at reset values after reset");

  a_cfg_rdata: assert property (@(posedge qdr_clk) disable iff (qdr_rst)
    cfg_valid && cfg_ready && !cfg_write |=> cfg_rvalid && cfg_rdata == cfg_exp)
    else log_error("config read returned a wrong value");

  a_cfg_rvalid_cause: assert property (@(posedge qdr_clk) disable iff (qdr_rst)
    cfg_rvalid |-> $past(cfg_valid && cfg_ready && !cfg_write))
    else log_error("cfg_rvalid without a config read");

  // config traffic only between host accesses
  a_cfg_idle: assert property (@(posedge qdr_clk) disable iff (qdr_rst)
    cfg_valid && cfg_ready |-> host_ready)
    else log_error("config transfer during a host access");

  // controller command follows the host request that started it
  a_qdr_cmd: assert property (@(posedge qdr_clk) disable iff (qdr_rst)
    qdr_req |-> qdr_addr == exp_burst && qdr_r == exp_rnw && qdr_w == !exp_rnw)
    else log_error("wrong controller address or direction");

  // no parity, the pad bits of both lanes stay low on the pins
  a_pad_zero: assert property (@(posedge qdr_clk) disable iff (qdr_rst)
    qdr_d.lanes[1].pad == 4'd0 && qdr_d.lanes[0].pad == 4'd0)
    else log_error("pad bits driven nonzero on qdr_d");

  a_rsp_data: assert property (@(posedge qdr_clk) disable iff (qdr_rst)
    rsp_valid && rsp_ready |-> rsp_rdata == exp_rdata)
    else log_error("wrong rsp_rdata");

  a_rsp_hold: assert property (@(posedge qdr_clk) disable iff (qdr_rst)
    rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_rdata) && !host_ready)
    else log_error("response not held under back-pressure");

  a_rsp_gap: assert property (@(posedge qdr_clk) disable iff (qdr_rst)
    $rose(rsp_valid) |-> ack_gap == exp_gap)
    else log_error("rsp_valid rose at the wrong distance from the ack cycle");

  a_no_overlap: assert property (@(posedge qdr_clk) disable iff (qdr_rst)
    rsp_valid |-> !host_ready)
    else log_error("host_ready high with a response pending");

  initial begin
    logic [27:0] bursts [3];
    logic [27:0] burst_a;
    logic [27:0] burst_b;
    int          b;
    int          w;
    int          pass;
    void'($urandom(32'hb75));
    qdr_rst       = 1'b1;
    host_valid    = 1'b0;
    host_rnw      = 1'b0;
    host_addr     = '0;
    host_wdata    = '0;
    host_be       = '0;
    rsp_ready     = 1'b0;
    cfg_valid     = 1'b0;
    cfg_write     = 1'b0;
    cfg_addr      = CFG_LATENCY;
    cfg_wdata     = '0;
    ack_delay     = 0;
    lat_exp       = `QDR_DEFAULT_LATENCY;
    model_lat     = `QDR_DEFAULT_LATENCY;
    fb_exp        = 1'b0;
    exp_writes    = 0;
    exp_reads     = 0;
    exp_rdata     = '0;
    exp_gap       = 0;
    cfg_exp       = '0;
    exp_burst     = '0;
    exp_rnw       = 1'b0;
    ack_gap       = 0;
    ref_shadow    = '0;
    err_count     = 0;
    timeout_count = 0;
    repeat (8) @(negedge qdr_clk);
    qdr_rst = 1'b0;

    // register defaults
    cfg_transfer(1'b0, CFG_LATENCY, 32'd0);
    cfg_transfer(1'b0, CFG_CONTROL, 32'd0);
    cfg_transfer(1'b0, CFG_WRITES, 32'd0);
    cfg_transfer(1'b0, CFG_READS, 32'd0);

    // lane mode, two write passes so later bytes merge over earlier ones
    for (b = 0; b < 3; b++) begin
      bursts[b] = 28'($urandom);
    end
    for (pass = 0; pass < 2; pass++) begin
      for (b = 0; b < 3; b++) begin
        for (w = 0; w < 4; w++) begin
          host_access(1'b0, bursts[b], 2'(w), $urandom, 4'($urandom));
        end
      end
    end
    for (b = 0; b < 3; b++) begin
      for (w = 0; w < 4; w++) begin
        host_access(1'b1, bursts[b], 2'(w), 32'd0, 4'd0);
      end
    end

    // full-burst write of B carries A's word 0 from the shadow
    burst_a = 28'($urandom);
    burst_b = burst_a ^ 28'h1;
    host_access(1'b0, burst_a, 2'd0, $urandom, 4'hf);
    cfg_transfer(1'b1, CFG_CONTROL, 32'd1);
    cfg_transfer(1'b0, CFG_CONTROL, 32'd0);
    host_access(1'b0, burst_b, 2'd1, $urandom, 4'h3);
    cfg_transfer(1'b1, CFG_CONTROL, 32'd0);
    for (w = 0; w < 4; w++) begin
      host_access(1'b1, burst_b, 2'(w), 32'd0, 4'd0);
    end

    // short latency
    cfg_transfer(1'b1, CFG_LATENCY, 32'd3);
    for (w = 0; w < 4; w++) begin
      host_access(1'b1, bursts[0], 2'(w), 32'd0, 4'd0);
    end
    // latency change issued mid-read has to wait for cfg_ready
    fork
      host_access(1'b1, bursts[1], 2'd2, 32'd0, 4'd0);
      begin
        repeat (3) @(negedge qdr_clk);
        cfg_transfer(1'b1, CFG_LATENCY, 32'd15);
      end
    join
    cfg_transfer(1'b0, CFG_LATENCY, 32'd0);
    for (w = 0; w < 4; w++) begin
      host_access(1'b0, bursts[2], 2'(w), $urandom, 4'($urandom));
      host_access(1'b1, bursts[2], 2'(w), 32'd0, 4'd0);
    end

    // out of range values clamp, then run at the minimum
    cfg_transfer(1'b1, CFG_LATENCY, 32'd40);
    cfg_transfer(1'b0, CFG_LATENCY, 32'd0);
    cfg_transfer(1'b1, CFG_LATENCY, 32'd0);
    cfg_transfer(1'b0, CFG_LATENCY, 32'd0);
    for (w = 0; w < 4; w++) begin
      host_access(1'b1, bursts[1], 2'(w), 32'd0, 4'd0);
    end

    // counters, clear on write, then count again
    cfg_transfer(1'b0, CFG_WRITES, 32'd0);
    cfg_transfer(1'b0, CFG_READS, 32'd0);
    cfg_transfer(1'b1, CFG_WRITES, 32'd0);
    cfg_transfer(1'b1, CFG_READS, 32'd0);
    cfg_transfer(1'b0, CFG_WRITES, 32'd0);
    cfg_transfer(1'b0, CFG_READS, 32'd0);
    host_access(1'b0, bursts[0], 2'd3, $urandom, 4'hf);
    host_access(1'b1, bursts[0], 2'd3, 32'd0, 4'd0);
    cfg_transfer(1'b0, CFG_WRITES, 32'd0);
    cfg_transfer(1'b0, CFG_READS, 32'd0);

    repeat (4) @(negedge qdr_clk);
    $display("assertion errors: %0d, timeouts: %0d", err_count, timeout_count);
    if (err_count == 0 && timeout_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* testbench/qdr_sram_model.sv */
module qdr_sram_model (
  input  logic        qdr_clk,
  input  logic        qdr_req,
  input  logic        qdr_r,
  input  logic        qdr_w,
  input  logic [27:0] qdr_addr,
  input  logic [71:0] qdr_d,
  input  logic [7:0]  qdr_be,
  input  int          ack_delay,
  input  int          latency,
  output logic        qdr_ack,
  output logic [71:0] qdr_q
);

  // one 144-bit burst per address, beat 0 in bits 71:0
  logic [143:0] mem [logic [27:0]];
  int           wait_cnt;
  int           rd_cnt;
  logic         wr_beat1;
  logic         rd_beat1;
  logic [27:0]  cur_addr;

  // byte writes, high nibble of be is the upper lane
  // pad bits are never stored so they read back as zero
  task automatic write_beat(input logic [27:0] a, input int beat, input logic [71:0] d,
                            input logic [7:0] be);
    logic [143:0] line;
    int           j;
    line = mem.exists(a) ? mem[a] : '0;
    for (j = 0; j < 4; j++) begin
      if (be[4+j]) begin
        line[72*beat + 36 + 8*j +: 8] = d[36 + 8*j +: 8];
      end
      if (be[j]) begin
        line[72*beat + 8*j +: 8] = d[8*j +: 8];
      end
    end
    mem[a] = line;
  endtask

  function automatic logic [71:0] read_beat(input logic [27:0] a, input int beat);
    logic [143:0] line;
    line = mem.exists(a) ? mem[a] : '0;
    return line[72*beat +: 72];
  endfunction

  initial begin
    qdr_ack  = 1'b0;
    qdr_q    = '1;
    wait_cnt = 0;
    rd_cnt   = 0;
    wr_beat1 = 1'b0;
    rd_beat1 = 1'b0;
    cur_addr = '0;
  end

  // everything moves on the falling edge, the bridge samples on the rising one
  always @(negedge qdr_clk) begin
    // idle bus shows all ones so a mistimed capture stands out
    qdr_q = '1;
    if (wr_beat1) begin
      write_beat(cur_addr, 1, qdr_d, qdr_be);
      wr_beat1 = 1'b0;
    end
    if (rd_beat1) begin
      qdr_q    = read_beat(cur_addr, 1);
      rd_beat1 = 1'b0;
    end
    // beat 0 lands latency cycles after the ack cycle
    if (rd_cnt > 0) begin
      rd_cnt--;
      if (rd_cnt == 0) begin
        qdr_q    = read_beat(cur_addr, 0);
        rd_beat1 = 1'b1;
      end
    end
    // ack is a single cycle, raised after ack_delay waiting cycles
    if (qdr_ack) begin
      qdr_ack  = 1'b0;
      wait_cnt = 0;
    end else if (qdr_req) begin
      if (wait_cnt >= ack_delay) begin
        qdr_ack  = 1'b1;
        cur_addr = qdr_addr;
        // the ack cycle carries beat 0 of a write
        if (qdr_w) begin
          write_beat(qdr_addr, 0, qdr_d, qdr_be);
          wr_beat1 = 1'b1;
        end
        if (qdr_r) begin
          rd_cnt = latency;
        end
      end else begin
        wait_cnt++;
      end
    end
  end

endmodule

/* logic/qdr_host_bridge.sv */
`include "qdr_params.svh"

module qdr_host_bridge
  import host_bus_pkg::*;
  import qdr_mem_pkg::*;
(
  input  logic        qdr_clk,
  input  logic        qdr_rst,
  // host request and response
  input  logic        host_valid,
  input  logic        host_rnw,
  input  host_addr_t  host_addr,
  input  logic [31:0] host_wdata,
  input  logic [3:0]  host_be,
  output logic        host_ready,
  output logic        rsp_valid,
  output logic [31:0] rsp_rdata,
  input  logic        rsp_ready,
  // configuration
  input  logic        cfg_valid,
  input  logic        cfg_write,
  input  cfg_reg_e    cfg_addr,
  input  logic [31:0] cfg_wdata,
  output logic        cfg_ready,
  output logic        cfg_rvalid,
  output logic [31:0] cfg_rdata,
  // controller port
  output logic        qdr_req,
  input  logic        qdr_ack,
  output logic [27:0] qdr_addr,
  output logic        qdr_r,
  output logic        qdr_w,
  output qdr_beat_u   qdr_d,
  output logic [7:0]  qdr_be,
  input  qdr_beat_u   qdr_q
);

  logic                     capture;
  logic                     beat_sel;
  logic                     busy;
  logic                     write_done;
  logic                     read_done;
  logic                     read_word_valid;
  logic [31:0]              read_word;
  logic [`QDR_LAT_BITS-1:0] read_latency;
  logic                     full_burst;

  qdr_bridge_csr csr_i (
    .qdr_clk(qdr_clk), .qdr_rst(qdr_rst),
    .cfg_valid(cfg_valid), .cfg_write(cfg_write), .cfg_addr(cfg_addr),
    .cfg_wdata(cfg_wdata), .cfg_ready(cfg_ready), .cfg_rvalid(cfg_rvalid),
    .cfg_rdata(cfg_rdata), .busy(busy), .write_done(write_done),
    .read_done(read_done), .read_latency(read_latency), .full_burst(full_burst)
  );

  qdr_access_sequencer seq_i (
    .qdr_clk(qdr_clk), .qdr_rst(qdr_rst),
    .host_valid(host_valid), .host_rnw(host_rnw), .host_addr(host_addr),
    .host_ready(host_ready), .rsp_valid(rsp_valid), .rsp_rdata(rsp_rdata),
    .rsp_ready(rsp_ready), .read_word_valid(read_word_valid), .read_word(read_word),
    .qdr_req(qdr_req), .qdr_r(qdr_r), .qdr_w(qdr_w), .qdr_addr(qdr_addr),
    .qdr_ack(qdr_ack), .capture(capture), .beat_sel(beat_sel), .busy(busy),
    .write_done(write_done), .read_done(read_done)
  );

  qdr_burst_assembler asm_i (
    .qdr_clk(qdr_clk), .qdr_rst(qdr_rst),
    .capture(capture), .host_rnw(host_rnw), .host_addr(host_addr),
    .host_wdata(host_wdata), .host_be(host_be), .beat_sel(beat_sel),
    .full_burst(full_burst), .qdr_d(qdr_d), .qdr_be(qdr_be)
  );

  qdr_read_return rdret_i (
    .qdr_clk(qdr_clk), .qdr_rst(qdr_rst),
    .capture(capture), .host_addr(host_addr), .qdr_ack(qdr_ack), .qdr_r(qdr_r),
    .read_latency(read_latency), .qdr_q(qdr_q),
    .read_word_valid(read_word_valid), .read_word(read_word)
  );

endmodule

/* logic/qdr_read_return.sv */
`include "qdr_params.svh"

module qdr_read_return
  import host_bus_pkg::*;
  import qdr_mem_pkg::*;
(
  input  logic                     qdr_clk,
  input  logic                     qdr_rst,
  input  logic                     capture,
  input  host_addr_t               host_addr,
  input  logic                     qdr_ack,
  input  logic                     qdr_r,
  input  logic [`QDR_LAT_BITS-1:0] read_latency,
  input  qdr_beat_u                qdr_q,
  output logic                     read_word_valid,
  output logic [31:0]              read_word
);

  // bit k set means the read ack was k+1 cycles ago
  logic [`QDR_MAX_LATENCY-1:0] ack_sr;
  logic                        beat0_mark;
  logic                        beat1_mark;
  logic [1:0]                  wid_q;
  logic                        take;

  // beat 0 sits on qdr_q exactly read_latency cycles after the ack cycle
  assign beat0_mark = ack_sr[read_latency - 1'b1];

  // wait for the beat that carries the addressed word
  assign take = wid_q[1] ? beat1_mark : beat0_mark;

  always_ff @(posedge qdr_clk) begin
    if (qdr_rst) begin
      ack_sr          <= '0;
      beat1_mark      <= 1'b0;
      read_word_valid <= 1'b0;
    end else begin
      ack_sr          <= {ack_sr[`QDR_MAX_LATENCY-2:0], qdr_ack & qdr_r};
      beat1_mark      <= beat0_mark;
      read_word_valid <= take;
    end
  end

  // word slot of the current access
  always_ff @(posedge qdr_clk) begin
    if (qdr_rst) begin
      wid_q <= 2'd0;
    end else if (capture) begin
      wid_q <= host_addr.word_id;
    end
  end

  // lane pick through the lanes view, word_id[0] clear is the upper lane
  // the word then holds until the next read lands
  always_ff @(posedge qdr_clk) begin
    if (take) begin
      read_word <= qdr_q.lanes[~wid_q[0]].data;
    end
  end

endmodule

/* logic/qdr_burst_assembler.sv */
module qdr_burst_assembler
  import host_bus_pkg::*;
  import qdr_mem_pkg::*;
(
  input  logic        qdr_clk,
  input  logic        qdr_rst,
  input  logic        capture,
  input  logic        host_rnw,
  input  host_addr_t  host_addr,
  input  logic [31:0] host_wdata,
  input  logic [3:0]  host_be,
  input  logic        beat_sel,
  input  logic        full_burst,
  output qdr_beat_u   qdr_d,
  output logic [7:0]  qdr_be
);

  // shadow of the whole 144-bit burst, index is the beat
  qdr_beat_u  shadow [2];
  logic [1:0] wid_q;
  logic [3:0] be_q;
  logic       wr_capture;
  logic [7:0] lane_be;

  assign wr_capture = capture & ~host_rnw;

  // word_id[1] picks the beat, word_id[0] clear means upper lane
  always_ff @(posedge qdr_clk) begin
    if (qdr_rst) begin
      shadow[0].raw <= '0;
      shadow[1].raw <= '0;
    end else if (wr_capture) begin
      shadow[host_addr.word_id[1]].lanes[~host_addr.word_id[0]] <=
        '{pad: 4'b0, data: host_wdata};
    end
  end

  // slot and byte enables of the last write, for the be generator
  always_ff @(posedge qdr_clk) begin
    if (qdr_rst) begin
      wid_q <= 2'd0;
      be_q  <= 4'd0;
    end else if (wr_capture) begin
      wid_q <= host_addr.word_id;
      be_q  <= host_be;
    end
  end

  // beat data built lane by lane, pads forced low
  always_comb begin
    qdr_d.lanes[1] = '{pad: 4'b0, data: shadow[beat_sel].lanes[1].data};
    qdr_d.lanes[0] = '{pad: 4'b0, data: shadow[beat_sel].lanes[0].data};
  end

  // host_be lands in the nibble of the addressed lane
  assign lane_be = wid_q[0] ? {4'b0, be_q} : {be_q, 4'b0};

  // full-burst mode rewrites every byte of both beats from the shadow
  // which fills a burst even when the controller ignores byte enables
  always_comb begin
    if (full_burst) begin
      qdr_be = 8'hff;
    end else if (beat_sel == wid_q[1]) begin
      qdr_be = lane_be;
    end else begin
      qdr_be = 8'h00;
    end
  end

endmodule

/* logic/qdr_access_sequencer.sv */
module qdr_access_sequencer
  import host_bus_pkg::*;
  import qdr_mem_pkg::*;
(
  input  logic        qdr_clk,
  input  logic        qdr_rst,
  input  logic        host_valid,
  input  logic        host_rnw,
  input  host_addr_t  host_addr,
  output logic        host_ready,
  output logic        rsp_valid,
  output logic [31:0] rsp_rdata,
  input  logic        rsp_ready,
  input  logic        read_word_valid,
  input  logic [31:0] read_word,
  output logic        qdr_req,
  output logic        qdr_r,
  output logic        qdr_w,
  output logic [27:0] qdr_addr,
  input  logic        qdr_ack,
  output logic        capture,
  output logic        beat_sel,
  output logic        busy,
  output logic        write_done,
  output logic        read_done
);

  // one-hot state bit positions
  localparam int S_IDLE = 0;
  localparam int S_REQ  = 1;
  localparam int S_WR1  = 2;
  localparam int S_RDW  = 3;
  localparam int S_RSP  = 4;

  logic [4:0]      state;
  logic [4:0]      state_nxt;
  logic            rnw_q;
  qdr_burst_addr_t burst_q;
  logic            rsp_fire;

  // new requests only when nothing is in flight or waiting for rsp_ready
  assign host_ready = state[S_IDLE];
  assign capture    = host_valid & host_ready;
  assign busy       = ~state[S_IDLE];

  // controller request stays up until the ack cycle
  assign qdr_req  = state[S_REQ];
  assign qdr_r    = qdr_req & rnw_q;
  assign qdr_w    = qdr_req & ~rnw_q;
  assign qdr_addr = burst_q;

  // beat 0 goes with the ack cycle, beat 1 the cycle after
  assign beat_sel = state[S_WR1];

  // a read response is offered in the same cycle the word arrives
  // and held in S_RSP if the host is not ready yet
  assign rsp_valid = state[S_RSP] | (state[S_RDW] & read_word_valid);
  // read_word stays put until the next capture, so it holds with rsp_valid
  assign rsp_rdata = rnw_q ? read_word : 32'd0;
  assign rsp_fire  = rsp_valid & rsp_ready;

  // completion strobes for the counters
  assign write_done = rsp_fire & ~rnw_q;
  assign read_done  = rsp_fire & rnw_q;

  always_comb begin
    state_nxt = state;
    case (1'b1)
      state[S_IDLE]: begin
        if (capture) begin
          state_nxt = 5'b1 << S_REQ;
        end
      end
      state[S_REQ]: begin
        if (qdr_ack) begin
          state_nxt = rnw_q ? (5'b1 << S_RDW) : (5'b1 << S_WR1);
        end
      end
      state[S_WR1]: begin
        state_nxt = 5'b1 << S_RSP;
      end
      state[S_RDW]: begin
        if (read_word_valid) begin
          state_nxt = rsp_ready ? (5'b1 << S_IDLE) : (5'b1 << S_RSP);
        end
      end
      state[S_RSP]: begin
        if (rsp_ready) begin
          state_nxt = 5'b1 << S_IDLE;
        end
      end
      // recover from an illegal encoding
      default: state_nxt = 5'b1 << S_IDLE;
    endcase
  end

  always_ff @(posedge qdr_clk) begin
    if (qdr_rst) begin
      state <= 5'b1 << S_IDLE;
      rnw_q <= 1'b0;
    end else begin
      state <= state_nxt;
      if (capture) begin
        rnw_q <= host_rnw;
      end
    end
  end

  // burst address is payload, loaded on the accepting edge
  always_ff @(posedge qdr_clk) begin
    if (capture) begin
      burst_q <= host_addr.burst;
    end
  end

  a_rw_exclusive: assert property (@(posedge qdr_clk) disable iff (qdr_rst)
    !(qdr_r && qdr_w));

  // controller may stall, the request must not drop before ack
  a_req_held: assert property (@(posedge qdr_clk) disable iff (qdr_rst)
    qdr_req && !qdr_ack |=> qdr_req);

  a_rsp_stable: assert property (@(posedge qdr_clk) disable iff (qdr_rst)
    rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_rdata));

endmodule

/* logic/qdr_bridge_csr.sv */
`include "qdr_params.svh"

module qdr_bridge_csr
  import host_bus_pkg::*;
(
  input  logic                     qdr_clk,
  input  logic                     qdr_rst,
  input  logic                     cfg_valid,
  input  logic                     cfg_write,
  input  cfg_reg_e                 cfg_addr,
  input  logic [31:0]              cfg_wdata,
  output logic                     cfg_ready,
  output logic                     cfg_rvalid,
  output logic [31:0]              cfg_rdata,
  input  logic                     busy,
  input  logic                     write_done,
  input  logic                     read_done,
  output logic [`QDR_LAT_BITS-1:0] read_latency,
  output logic                     full_burst
);

  localparam logic [`QDR_LAT_BITS-1:0] LAT_DEF = `QDR_DEFAULT_LATENCY;
  localparam logic [`QDR_LAT_BITS-1:0] LAT_MIN = `QDR_MIN_LATENCY;
  localparam logic [`QDR_LAT_BITS-1:0] LAT_MAX = `QDR_MAX_LATENCY;

  logic                     cfg_fire;
  logic [`QDR_LAT_BITS-1:0] lat_clamped;
  logic [15:0]              write_count;
  logic [15:0]              read_count;

  // hold off config traffic for the whole host access
  assign cfg_ready = ~busy;
  assign cfg_fire  = cfg_valid & cfg_ready;

  // out of range latency writes snap to the nearest legal value
  always_comb begin
    if (cfg_wdata < 32'(LAT_MIN)) begin
      lat_clamped = LAT_MIN;
    end else if (cfg_wdata > 32'(LAT_MAX)) begin
      lat_clamped = LAT_MAX;
    end else begin
      lat_clamped = cfg_wdata[`QDR_LAT_BITS-1:0];
    end
  end

  // writable registers and the completion counters
  always_ff @(posedge qdr_clk) begin
    if (qdr_rst) begin
      read_latency <= LAT_DEF;
      full_burst   <= 1'b0;
      write_count  <= '0;
      read_count   <= '0;
    end else begin
      if (write_done) begin
        write_count <= write_count + 16'd1;
      end
      if (read_done) begin
        read_count <= read_count + 16'd1;
      end
      // a clear wins over a count in the same cycle
      if (cfg_fire && cfg_write) begin
        case (cfg_addr)
          CFG_LATENCY: read_latency <= lat_clamped;
          CFG_CONTROL: full_burst   <= cfg_wdata[0];
          CFG_WRITES:  write_count  <= '0;
          CFG_READS:   read_count   <= '0;
          default:     ;
        endcase
      end
    end
  end

  // read data lands one cycle after the transfer
  always_ff @(posedge qdr_clk) begin
    if (qdr_rst) begin
      cfg_rvalid <= 1'b0;
    end else begin
      cfg_rvalid <= cfg_fire & ~cfg_write;
    end
  end

  always_ff @(posedge qdr_clk) begin
    if (cfg_fire && !cfg_write) begin
      case (cfg_addr)
        CFG_LATENCY: cfg_rdata <= {{(32-`QDR_LAT_BITS){1'b0}}, read_latency};
        CFG_CONTROL: cfg_rdata <= {31'b0, full_burst};
        CFG_WRITES:  cfg_rdata <= {16'b0, write_count};
        default:     cfg_rdata <= {16'b0, read_count};
      endcase
    end
  end

  // the read tracker taps at read_latency, so it must stay legal
  a_latency_range: assert property (@(posedge qdr_clk) disable iff (qdr_rst)
    (read_latency >= LAT_MIN) && (read_latency <= LAT_MAX));

endmodule

/* logic/qdr_mem_pkg.sv */
package qdr_mem_pkg;

  // one 36-bit lane of a QDR beat
  // pad holds the parity positions, always driven as zero here
  typedef struct packed {
    logic [3:0]  pad;
    logic [31:0] data;
  } qdr_lane_t;

  // one 72-bit beat, seen either as the raw pin word or as two lanes
  // lanes[1] is the upper lane, bits 71:36
  typedef union packed {
    logic [71:0]           raw;
    qdr_lane_t [1:0]       lanes;
  } qdr_beat_u;

  // burst address on the controller port, one step per 144-bit burst
  typedef logic [27:0] qdr_burst_addr_t;

  // word placement inside a burst
  //   word_id 0 -> beat 0, upper lane
  //   word_id 1 -> beat 0, lower lane
  //   word_id 2 -> beat 1, upper lane
  //   word_id 3 -> beat 1, lower lane
  // so word_id[1] picks the beat and word_id[0] set means lower lane
  //
  // qdr_be is 8 bits per beat
  // high nibble enables the upper lane, one bit per byte in host_be order
  // low nibble does the same for the lower lane

endpackage

/* logic/host_bus_pkg.sv */
package host_bus_pkg;

  // host byte address split into its burst, word and byte parts
  // one burst holds four 32-bit words, 16 bytes of host space
  typedef struct packed {
    // burst number, goes straight to qdr_addr
    logic [27:0] burst;
    // which 32-bit slot of the 144-bit burst
    logic [1:0]  word_id;
    // byte offset inside the word, ignored by the bridge
    logic [1:0]  byte_off;
  } host_addr_t;

  // configuration register map
  typedef enum logic [1:0] {
    // read latency in cycles, read/write, clamped to the legal range
    CFG_LATENCY = 2'd0,
    // bit 0 selects full-burst write mode
    CFG_CONTROL = 2'd1,
    // completed write count
    // read-only, any write clears it
    CFG_WRITES  = 2'd2,
    // completed read count, same rules as the write count
    CFG_READS   = 2'd3
  } cfg_reg_e;

endpackage

/* logic/qdr_params.svh */
`ifndef QDR_PARAMS_SVH
`define QDR_PARAMS_SVH

// read latency as seen at the controller port, in qdr_clk cycles
// from the ack cycle to the cycle that carries beat 0 on qdr_q

// value loaded into the latency register on reset
`define QDR_DEFAULT_LATENCY 10

// smallest latency the read tracker can tap
`define QDR_MIN_LATENCY 2

// largest latency, also the length of the read tracker shift register
`define QDR_MAX_LATENCY 15

// width of the latency field in the config register and on read_latency
`define QDR_LAT_BITS 4

`endif
